// File: common/udp_ip_pkg.sv
`default_nettype none

package udp_ip_pkg;

  // Payload beat geometry
  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  // IP protocol number for UDP
  localparam logic [7:0] PROTO_UDP = 8'd17;

  // IP header (20) plus UDP header (8)
  localparam logic [15:0] IP_UDP_HDR_BYTES = 16'd28;

  // IP header as seen on the send and receive channels
  typedef struct packed {
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] length;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
    logic        is_roce;
  } ip_hdr_t;

  // UDP send request
  typedef struct packed {
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [7:0]  ttl;
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
    logic [15:0] source_port;
    logic [15:0] dest_port;
    logic [15:0] length;
    logic [15:0] checksum;
  } udp_hdr_t;

  // One payload beat, last marks the end of the frame
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
    logic                  user;
  } beat_t;

endpackage

`default_nettype wire

// File: design/skid_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module skid_buffer #(
  parameter type T = logic
) (
  input  wire logic clk,
  input  wire logic rst,

  input  wire logic in_valid,
  output logic      in_ready,
  input  wire T     in_data,

  output logic      out_valid,
  input  wire logic out_ready,
  output T          out_data
);

  logic out_valid_r;
  T     out_data_r;
  logic skid_valid;
  T     skid_data;
  logic out_free;

  // Output slot empties or moves on this cycle
  assign out_free = out_ready || !out_valid_r;

  // Ready only drops once the skid entry holds a beat
  assign in_ready  = !skid_valid;
  assign out_valid = out_valid_r;
  assign out_data  = out_data_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_r <= 1'b0;
      skid_valid  <= 1'b0;
    end else if (out_free) begin
      if (skid_valid) begin
        out_valid_r <= 1'b1;
        skid_valid  <= 1'b0;
      end else begin
        out_valid_r <= in_valid;
      end
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data_r <= skid_valid ? skid_data : in_data;
    end
    // Skid entry is only read while skid_valid is set
    if (!skid_valid) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: rx/ip_rx_demux.sv
`timescale 1ns/1ns
`default_nettype none

module ip_rx_demux (
  input  wire logic                clk,
  input  wire logic                rst,

  input  wire logic                in_hdr_valid,
  output logic                     in_hdr_ready,
  input  wire udp_ip_pkg::ip_hdr_t in_hdr,
  input  wire logic                in_beat_valid,
  output logic                     in_beat_ready,
  input  wire udp_ip_pkg::beat_t   in_beat,

  output logic                     udp_hdr_valid,
  input  wire logic                udp_hdr_ready,
  output udp_ip_pkg::ip_hdr_t      udp_hdr,
  output logic                     udp_beat_valid,
  input  wire logic                udp_beat_ready,
  output udp_ip_pkg::beat_t        udp_beat,

  output logic                     ip_hdr_valid,
  input  wire logic                ip_hdr_ready,
  output udp_ip_pkg::ip_hdr_t      ip_hdr,
  output logic                     ip_beat_valid,
  input  wire logic                ip_beat_ready,
  output udp_ip_pkg::beat_t        ip_beat
);

  import udp_ip_pkg::*;

  logic frame_open;
  logic route_udp;
  logic hdr_is_udp;
  logic hdr_fire;
  logic last_fire;

  assign hdr_is_udp = (in_hdr.protocol == PROTO_UDP);

  // Headers wait while a frame is still open
  assign udp_hdr_valid = in_hdr_valid && !frame_open && hdr_is_udp;
  assign ip_hdr_valid  = in_hdr_valid && !frame_open && !hdr_is_udp;
  assign in_hdr_ready  = !frame_open && (hdr_is_udp ? udp_hdr_ready : ip_hdr_ready);
  assign udp_hdr       = in_hdr;
  assign ip_hdr        = in_hdr;

  // Payload follows the route taken by its header
  assign udp_beat_valid = in_beat_valid && frame_open && route_udp;
  assign ip_beat_valid  = in_beat_valid && frame_open && !route_udp;
  assign in_beat_ready  = frame_open && (route_udp ? udp_beat_ready : ip_beat_ready);
  assign udp_beat       = in_beat;
  assign ip_beat        = in_beat;

  assign hdr_fire  = in_hdr_valid && in_hdr_ready;
  assign last_fire = in_beat_valid && in_beat_ready && in_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_open <= 1'b0;
      route_udp  <= 1'b0;
    end else if (hdr_fire) begin
      frame_open <= 1'b1;
      route_udp  <= hdr_is_udp;
    end else if (last_fire) begin
      frame_open <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tx/udp_tx_framer.sv
`timescale 1ns/1ns
`default_nettype none

module udp_tx_framer #(
  parameter logic [15:0] ROCE_UDP_PORT = 16'd4791
) (
  input  wire logic                 clk,
  input  wire logic                 rst,

  input  wire logic                 udp_hdr_valid,
  output logic                      udp_hdr_ready,
  input  wire udp_ip_pkg::udp_hdr_t udp_hdr,

  input  wire logic                 in_beat_valid,
  output logic                      in_beat_ready,
  input  wire udp_ip_pkg::beat_t    in_beat,

  output logic                      ip_hdr_valid,
  input  wire logic                 ip_hdr_ready,
  output udp_ip_pkg::ip_hdr_t       ip_hdr,

  output logic                      out_beat_valid,
  input  wire logic                 out_beat_ready,
  output udp_ip_pkg::beat_t         out_beat
);

  import udp_ip_pkg::*;

  ip_hdr_t framed_hdr;

  // IP header built from the UDP send request
  always_comb begin
    framed_hdr.dscp      = udp_hdr.dscp;
    framed_hdr.ecn       = udp_hdr.ecn;
    framed_hdr.length    = udp_hdr.length + IP_UDP_HDR_BYTES;
    framed_hdr.ttl       = udp_hdr.ttl;
    framed_hdr.protocol  = PROTO_UDP;
    framed_hdr.source_ip = udp_hdr.source_ip;
    framed_hdr.dest_ip   = udp_hdr.dest_ip;
    // RoCEv2 rides on a fixed UDP destination port
    framed_hdr.is_roce   = (udp_hdr.dest_port == ROCE_UDP_PORT);
  end

  skid_buffer #(
    .T(ip_hdr_t)
  ) hdr_slice (
    .clk      (clk),
    .rst      (rst),
    .in_valid (udp_hdr_valid),
    .in_ready (udp_hdr_ready),
    .in_data  (framed_hdr),
    .out_valid(ip_hdr_valid),
    .out_ready(ip_hdr_ready),
    .out_data (ip_hdr)
  );

  // Payload is carried through unchanged
  skid_buffer #(
    .T(beat_t)
  ) beat_slice (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_beat_valid),
    .in_ready (in_beat_ready),
    .in_data  (in_beat),
    .out_valid(out_beat_valid),
    .out_ready(out_beat_ready),
    .out_data (out_beat)
  );

endmodule

`default_nettype wire

// File: tx/ip_tx_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module ip_tx_arbiter (
  input  wire logic                clk,
  input  wire logic                rst,

  input  wire logic                udp_hdr_valid,
  output logic                     udp_hdr_ready,
  input  wire udp_ip_pkg::ip_hdr_t udp_hdr,
  input  wire logic                udp_beat_valid,
  output logic                     udp_beat_ready,
  input  wire udp_ip_pkg::beat_t   udp_beat,

  input  wire logic                raw_hdr_valid,
  output logic                     raw_hdr_ready,
  input  wire udp_ip_pkg::ip_hdr_t raw_hdr,
  input  wire logic                raw_beat_valid,
  output logic                     raw_beat_ready,
  input  wire udp_ip_pkg::beat_t   raw_beat,

  output logic                     out_hdr_valid,
  input  wire logic                out_hdr_ready,
  output udp_ip_pkg::ip_hdr_t      out_hdr,
  output logic                     out_beat_valid,
  input  wire logic                out_beat_ready,
  output udp_ip_pkg::beat_t        out_beat
);

  import udp_ip_pkg::*;

  logic    grant_udp;
  logic    grant_raw;
  logic    busy;
  logic    pick_udp;
  logic    hdr_in_valid;
  logic    hdr_in_ready;
  ip_hdr_t hdr_in;
  logic    beat_in_valid;
  logic    beat_in_ready;
  beat_t   beat_in;

  assign busy = grant_udp || grant_raw;

  // Fixed priority, UDP wins whenever its header is waiting
  assign pick_udp = udp_hdr_valid;

  assign hdr_in_valid  = !busy && (udp_hdr_valid || raw_hdr_valid);
  assign hdr_in        = pick_udp ? udp_hdr : raw_hdr;
  assign udp_hdr_ready = !busy && pick_udp && hdr_in_ready;
  assign raw_hdr_ready = !busy && !pick_udp && hdr_in_ready;

  // Only the granted source may move payload
  assign beat_in_valid  = (grant_udp && udp_beat_valid) || (grant_raw && raw_beat_valid);
  assign beat_in        = grant_udp ? udp_beat : raw_beat;
  assign udp_beat_ready = grant_udp && beat_in_ready;
  assign raw_beat_ready = grant_raw && beat_in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_udp <= 1'b0;
      grant_raw <= 1'b0;
    end else if (hdr_in_valid && hdr_in_ready) begin
      grant_udp <= pick_udp;
      grant_raw <= !pick_udp;
    end else if (beat_in_valid && beat_in_ready && beat_in.last) begin
      grant_udp <= 1'b0;
      grant_raw <= 1'b0;
    end
  end

  skid_buffer #(
    .T(ip_hdr_t)
  ) hdr_slice (
    .clk      (clk),
    .rst      (rst),
    .in_valid (hdr_in_valid),
    .in_ready (hdr_in_ready),
    .in_data  (hdr_in),
    .out_valid(out_hdr_valid),
    .out_ready(out_hdr_ready),
    .out_data (out_hdr)
  );

  skid_buffer #(
    .T(beat_t)
  ) beat_slice (
    .clk      (clk),
    .rst      (rst),
    .in_valid (beat_in_valid),
    .in_ready (beat_in_ready),
    .in_data  (beat_in),
    .out_valid(out_beat_valid),
    .out_ready(out_beat_ready),
    .out_data (out_beat)
  );

endmodule

`default_nettype wire

// File: design/udp_ip_switch.sv
`timescale 1ns/1ns
`default_nettype none

module udp_ip_switch #(
  parameter logic [15:0] ROCE_UDP_PORT = 16'd4791
) (
  input  wire logic                 clk,
  input  wire logic                 rst,

  // Received IP frames
  input  wire logic                 rx_hdr_valid,
  output logic                      rx_hdr_ready,
  input  wire udp_ip_pkg::ip_hdr_t  rx_hdr,
  input  wire logic                 rx_beat_valid,
  output logic                      rx_beat_ready,
  input  wire udp_ip_pkg::beat_t    rx_beat,

  output logic                      udp_rx_hdr_valid,
  input  wire logic                 udp_rx_hdr_ready,
  output udp_ip_pkg::ip_hdr_t       udp_rx_hdr,
  output logic                      udp_rx_beat_valid,
  input  wire logic                 udp_rx_beat_ready,
  output udp_ip_pkg::beat_t         udp_rx_beat,

  output logic                      ip_rx_hdr_valid,
  input  wire logic                 ip_rx_hdr_ready,
  output udp_ip_pkg::ip_hdr_t       ip_rx_hdr,
  output logic                      ip_rx_beat_valid,
  input  wire logic                 ip_rx_beat_ready,
  output udp_ip_pkg::beat_t         ip_rx_beat,

  // Send side
  input  wire logic                 udp_tx_hdr_valid,
  output logic                      udp_tx_hdr_ready,
  input  wire udp_ip_pkg::udp_hdr_t udp_tx_hdr,
  input  wire logic                 udp_tx_beat_valid,
  output logic                      udp_tx_beat_ready,
  input  wire udp_ip_pkg::beat_t    udp_tx_beat,

  input  wire logic                 raw_tx_hdr_valid,
  output logic                      raw_tx_hdr_ready,
  input  wire udp_ip_pkg::ip_hdr_t  raw_tx_hdr,
  input  wire logic                 raw_tx_beat_valid,
  output logic                      raw_tx_beat_ready,
  input  wire udp_ip_pkg::beat_t    raw_tx_beat,

  output logic                      tx_hdr_valid,
  input  wire logic                 tx_hdr_ready,
  output udp_ip_pkg::ip_hdr_t       tx_hdr,
  output logic                      tx_beat_valid,
  input  wire logic                 tx_beat_ready,
  output udp_ip_pkg::beat_t         tx_beat
);

  import udp_ip_pkg::*;

  // Framer to arbiter
  logic    framed_hdr_valid;
  logic    framed_hdr_ready;
  ip_hdr_t framed_hdr;
  logic    framed_beat_valid;
  logic    framed_beat_ready;
  beat_t   framed_beat;

  ip_rx_demux rx_demux (
    .clk(clk), .rst(rst),
    .in_hdr_valid(rx_hdr_valid), .in_hdr_ready(rx_hdr_ready), .in_hdr(rx_hdr),
    .in_beat_valid(rx_beat_valid), .in_beat_ready(rx_beat_ready), .in_beat(rx_beat),
    .udp_hdr_valid(udp_rx_hdr_valid), .udp_hdr_ready(udp_rx_hdr_ready),
    .udp_hdr(udp_rx_hdr),
    .udp_beat_valid(udp_rx_beat_valid), .udp_beat_ready(udp_rx_beat_ready),
    .udp_beat(udp_rx_beat),
    .ip_hdr_valid(ip_rx_hdr_valid), .ip_hdr_ready(ip_rx_hdr_ready), .ip_hdr(ip_rx_hdr),
    .ip_beat_valid(ip_rx_beat_valid), .ip_beat_ready(ip_rx_beat_ready),
    .ip_beat(ip_rx_beat)
  );

  udp_tx_framer #(
    .ROCE_UDP_PORT(ROCE_UDP_PORT)
  ) tx_framer (
    .clk(clk), .rst(rst),
    .udp_hdr_valid(udp_tx_hdr_valid), .udp_hdr_ready(udp_tx_hdr_ready),
    .udp_hdr(udp_tx_hdr),
    .in_beat_valid(udp_tx_beat_valid), .in_beat_ready(udp_tx_beat_ready),
    .in_beat(udp_tx_beat),
    .ip_hdr_valid(framed_hdr_valid), .ip_hdr_ready(framed_hdr_ready),
    .ip_hdr(framed_hdr),
    .out_beat_valid(framed_beat_valid), .out_beat_ready(framed_beat_ready),
    .out_beat(framed_beat)
  );

  ip_tx_arbiter tx_arbiter (
    .clk(clk), .rst(rst),
    .udp_hdr_valid(framed_hdr_valid), .udp_hdr_ready(framed_hdr_ready),
    .udp_hdr(framed_hdr),
    .udp_beat_valid(framed_beat_valid), .udp_beat_ready(framed_beat_ready),
    .udp_beat(framed_beat),
    .raw_hdr_valid(raw_tx_hdr_valid), .raw_hdr_ready(raw_tx_hdr_ready),
    .raw_hdr(raw_tx_hdr),
    .raw_beat_valid(raw_tx_beat_valid), .raw_beat_ready(raw_tx_beat_ready),
    .raw_beat(raw_tx_beat),
    .out_hdr_valid(tx_hdr_valid), .out_hdr_ready(tx_hdr_ready), .out_hdr(tx_hdr),
    .out_beat_valid(tx_beat_valid), .out_beat_ready(tx_beat_ready), .out_beat(tx_beat)
  );

endmodule

`default_nettype wire

// File: test/udp_ip_switch_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module udp_ip_switch_asserts (
  input wire logic                clk,
  input wire logic                rst,
  input wire logic                udp_rx_hdr_valid,
  input wire logic                udp_rx_hdr_ready,
  input wire udp_ip_pkg::ip_hdr_t udp_rx_hdr,
  input wire logic                udp_rx_beat_valid,
  input wire logic                udp_rx_beat_ready,
  input wire udp_ip_pkg::beat_t   udp_rx_beat,
  input wire logic                ip_rx_hdr_valid,
  input wire logic                ip_rx_hdr_ready,
  input wire udp_ip_pkg::ip_hdr_t ip_rx_hdr,
  input wire logic                ip_rx_beat_valid,
  input wire logic                ip_rx_beat_ready,
  input wire udp_ip_pkg::beat_t   ip_rx_beat,
  input wire logic                tx_hdr_valid,
  input wire logic                tx_hdr_ready,
  input wire udp_ip_pkg::ip_hdr_t tx_hdr,
  input wire logic                tx_beat_valid,
  input wire logic                tx_beat_ready,
  input wire udp_ip_pkg::beat_t   tx_beat,
  input wire logic                framed_hdr_valid,
  input wire logic                framed_hdr_ready,
  input wire logic                framed_beat_valid,
  input wire logic                framed_beat_ready,
  input wire udp_ip_pkg::beat_t   framed_beat,
  input wire logic                raw_tx_hdr_valid,
  input wire logic                raw_tx_hdr_ready,
  input wire logic                raw_tx_beat_valid,
  input wire logic                raw_tx_beat_ready,
  input wire udp_ip_pkg::beat_t   raw_tx_beat
);

  int   fail_count = 0;
  logic udp_owns_tx;
  logic raw_owns_tx;
  logic udp_rx_open;
  logic ip_rx_open;

  // Frame ownership seen from the handshakes alone
  always_ff @(posedge clk) begin
    if (rst) begin
      udp_owns_tx <= 1'b0;
      raw_owns_tx <= 1'b0;
      udp_rx_open <= 1'b0;
      ip_rx_open  <= 1'b0;
    end else begin
      if (framed_hdr_valid && framed_hdr_ready) begin
        udp_owns_tx <= 1'b1;
      end else if (framed_beat_valid && framed_beat_ready && framed_beat.last) begin
        udp_owns_tx <= 1'b0;
      end
      if (raw_tx_hdr_valid && raw_tx_hdr_ready) begin
        raw_owns_tx <= 1'b1;
      end else if (raw_tx_beat_valid && raw_tx_beat_ready && raw_tx_beat.last) begin
        raw_owns_tx <= 1'b0;
      end
      if (udp_rx_hdr_valid && udp_rx_hdr_ready) begin
        udp_rx_open <= 1'b1;
      end else if (udp_rx_beat_valid && udp_rx_beat_ready && udp_rx_beat.last) begin
        udp_rx_open <= 1'b0;
      end
      if (ip_rx_hdr_valid && ip_rx_hdr_ready) begin
        ip_rx_open <= 1'b1;
      end else if (ip_rx_beat_valid && ip_rx_beat_ready && ip_rx_beat.last) begin
        ip_rx_open <= 1'b0;
      end
    end
  end

  // Stalled outputs hold valid and data
  a_tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
    else begin
      fail_count++;
      $error("tx_hdr changed while stalled");
    end
  a_tx_beat_hold: assert property (@(posedge clk) disable iff (rst)
    tx_beat_valid && !tx_beat_ready |=> tx_beat_valid && $stable(tx_beat))
    else begin
      fail_count++;
      $error("tx_beat changed while stalled");
    end
  a_udp_rx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    udp_rx_hdr_valid && !udp_rx_hdr_ready |=> udp_rx_hdr_valid && $stable(udp_rx_hdr))
    else begin
      fail_count++;
      $error("udp_rx_hdr changed while stalled");
    end
  a_udp_rx_beat_hold: assert property (@(posedge clk) disable iff (rst)
    udp_rx_beat_valid && !udp_rx_beat_ready |=> udp_rx_beat_valid && $stable(udp_rx_beat))
    else begin
      fail_count++;
      $error("udp_rx_beat changed while stalled");
    end
  a_ip_rx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
    ip_rx_hdr_valid && !ip_rx_hdr_ready |=> ip_rx_hdr_valid && $stable(ip_rx_hdr))
    else begin
      fail_count++;
      $error("ip_rx_hdr changed while stalled");
    end
  a_ip_rx_beat_hold: assert property (@(posedge clk) disable iff (rst)
    ip_rx_beat_valid && !ip_rx_beat_ready |=> ip_rx_beat_valid && $stable(ip_rx_beat))
    else begin
      fail_count++;
      $error("ip_rx_beat changed while stalled");
    end

  a_idle_after_reset: assert property (@(posedge clk) $fell(rst) |->
    !(tx_hdr_valid || tx_beat_valid || udp_rx_hdr_valid || udp_rx_beat_valid ||
      ip_rx_hdr_valid || ip_rx_beat_valid))
    else begin
      fail_count++;
      $error("output valid high right after reset");
    end

  // Source without the grant stays blocked until the owner's last beat
  a_udp_grant_held: assert property (@(posedge clk) disable iff (rst)
    udp_owns_tx |-> !raw_tx_hdr_ready && !raw_tx_beat_ready)
    else begin
      fail_count++;
      $error("raw input ready while a UDP frame owns the arbiter");
    end
  a_raw_grant_held: assert property (@(posedge clk) disable iff (rst)
    raw_owns_tx |-> !framed_hdr_ready && !framed_beat_ready)
    else begin
      fail_count++;
      $error("UDP input ready while a raw frame owns the arbiter");
    end

  a_rx_route_held: assert property (@(posedge clk) disable iff (rst)
    !(udp_rx_open && ip_rx_beat_valid) && !(ip_rx_open && udp_rx_beat_valid))
    else begin
      fail_count++;
      $error("payload on the other receive output while a frame is open");
    end

endmodule

bind udp_ip_switch udp_ip_switch_asserts checks (
  .clk(clk), .rst(rst),
  .udp_rx_hdr_valid(udp_rx_hdr_valid), .udp_rx_hdr_ready(udp_rx_hdr_ready),
  .udp_rx_hdr(udp_rx_hdr),
  .udp_rx_beat_valid(udp_rx_beat_valid), .udp_rx_beat_ready(udp_rx_beat_ready),
  .udp_rx_beat(udp_rx_beat),
  .ip_rx_hdr_valid(ip_rx_hdr_valid), .ip_rx_hdr_ready(ip_rx_hdr_ready),
  .ip_rx_hdr(ip_rx_hdr),
  .ip_rx_beat_valid(ip_rx_beat_valid), .ip_rx_beat_ready(ip_rx_beat_ready),
  .ip_rx_beat(ip_rx_beat),
  .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready), .tx_hdr(tx_hdr),
  .tx_beat_valid(tx_beat_valid), .tx_beat_ready(tx_beat_ready), .tx_beat(tx_beat),
  .framed_hdr_valid(framed_hdr_valid), .framed_hdr_ready(framed_hdr_ready),
  .framed_beat_valid(framed_beat_valid), .framed_beat_ready(framed_beat_ready),
  .framed_beat(framed_beat),
  .raw_tx_hdr_valid(raw_tx_hdr_valid), .raw_tx_hdr_ready(raw_tx_hdr_ready),
  .raw_tx_beat_valid(raw_tx_beat_valid), .raw_tx_beat_ready(raw_tx_beat_ready),
  .raw_tx_beat(raw_tx_beat)
);

`default_nettype wire

// File: test/tb_udp_ip_switch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_udp_ip_switch;

  import udp_ip_pkg::*;

  localparam int PERIOD = 40;
  localparam int NUM_TESTS = 6;
  localparam int MAX_BEATS = 4;
  localparam logic [15:0] ROCE_PORT = 16'd4791;
  localparam logic [7:0] TAG_UDP = 8'ha5;
  localparam logic [7:0] TAG_RAW = 8'h5a;

  logic clk = 1'b0;
  logic rst;
  logic rx_hdr_valid, rx_hdr_ready, rx_beat_valid, rx_beat_ready;
  ip_hdr_t rx_hdr;
  beat_t rx_beat;
  logic udp_rx_hdr_valid, udp_rx_hdr_ready, udp_rx_beat_valid, udp_rx_beat_ready;
  ip_hdr_t udp_rx_hdr;
  beat_t udp_rx_beat;
  logic ip_rx_hdr_valid, ip_rx_hdr_ready, ip_rx_beat_valid, ip_rx_beat_ready;
  ip_hdr_t ip_rx_hdr;
  beat_t ip_rx_beat;
  logic udp_tx_hdr_valid, udp_tx_hdr_ready, udp_tx_beat_valid, udp_tx_beat_ready;
  udp_hdr_t udp_tx_hdr;
  beat_t udp_tx_beat;
  logic raw_tx_hdr_valid, raw_tx_hdr_ready, raw_tx_beat_valid, raw_tx_beat_ready;
  ip_hdr_t raw_tx_hdr;
  beat_t raw_tx_beat;
  logic tx_hdr_valid, tx_hdr_ready, tx_beat_valid, tx_beat_ready;
  ip_hdr_t tx_hdr;
  beat_t tx_beat;

  // Expected traffic per output, tx split by source
  ip_hdr_t udp_rx_hdr_q[$], ip_rx_hdr_q[$], tx_udp_hdr_q[$], tx_raw_hdr_q[$];
  beat_t udp_rx_beat_q[$], ip_rx_beat_q[$], tx_udp_beat_q[$], tx_raw_beat_q[$];
  bit hdr_order[$];
  int beat_src;
  int errors;
  int tests_run;
  int tests_failed;
  logic rand_ready;
  logic [31:0] rng_state = 32'he7ab;

  udp_ip_switch #(.ROCE_UDP_PORT(ROCE_PORT)) dut (.*);

  always #(PERIOD / 2) clk = !clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Failures seen here plus those of the bound checker
  function automatic int total_errors();
    return errors + dut.checks.fail_count;
  endfunction

  function automatic beat_t make_beat(input logic [7:0] tag, input logic last);
    beat_t b;
    b.data = {tag, 24'(next_rand()), next_rand()};
    b.keep = 8'(next_rand());
    b.user = 1'(next_rand());
    b.last = last;
    return b;
  endfunction

  function automatic ip_hdr_t rand_ip_hdr(input logic udp_proto);
    ip_hdr_t h;
    h = {9'(next_rand()), next_rand(), next_rand(), next_rand()};
    h.protocol = udp_proto ? 8'd17 : 8'(next_rand());
    if (!udp_proto && h.protocol == 8'd17) h.protocol = 8'd6;
    return h;
  endfunction

  function automatic udp_hdr_t rand_udp_hdr(input logic roce);
    udp_hdr_t u;
    u = {16'(next_rand()), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
    if (roce) u.dest_port = ROCE_PORT;
    else if (u.dest_port == ROCE_PORT) u.dest_port = 16'd53;
    return u;
  endfunction

  // IP header that a UDP send must turn into
  function automatic ip_hdr_t expect_framed(input udp_hdr_t u);
    ip_hdr_t h;
    h.dscp = u.dscp;
    h.ecn = u.ecn;
    h.length = u.length + 16'd28;
    h.ttl = u.ttl;
    h.protocol = 8'd17;
    h.source_ip = u.source_ip;
    h.dest_ip = u.dest_ip;
    h.is_roce = (u.dest_port == 16'd4791);
    return h;
  endfunction

  function automatic int rand_len();
    return int'(2'(next_rand())) + 1;
  endfunction

  task automatic check_hdr(input string name, input ip_hdr_t got, input ip_hdr_t exp);
    assert (got == exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    assert (got == exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic unexpected(input string name);
    $display("transfer on %s when none was expected", name);
    errors++;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (udp_rx_hdr_valid && udp_rx_hdr_ready) begin
        if (udp_rx_hdr_q.size() == 0) unexpected("udp_rx_hdr");
        else check_hdr("udp_rx_hdr", udp_rx_hdr, udp_rx_hdr_q.pop_front());
      end
      if (udp_rx_beat_valid && udp_rx_beat_ready) begin
        if (udp_rx_beat_q.size() == 0) unexpected("udp_rx_beat");
        else check_beat("udp_rx_beat", udp_rx_beat, udp_rx_beat_q.pop_front());
      end
      if (ip_rx_hdr_valid && ip_rx_hdr_ready) begin
        if (ip_rx_hdr_q.size() == 0) unexpected("ip_rx_hdr");
        else check_hdr("ip_rx_hdr", ip_rx_hdr, ip_rx_hdr_q.pop_front());
      end
      if (ip_rx_beat_valid && ip_rx_beat_ready) begin
        if (ip_rx_beat_q.size() == 0) unexpected("ip_rx_beat");
        else check_beat("ip_rx_beat", ip_rx_beat, ip_rx_beat_q.pop_front());
      end
      // Raw sends never carry protocol 17, so it names the source
      if (tx_hdr_valid && tx_hdr_ready) begin
        hdr_order.push_back(tx_hdr.protocol == 8'd17);
        if (tx_hdr.protocol == 8'd17) begin
          if (tx_udp_hdr_q.size() == 0) unexpected("tx_hdr");
          else check_hdr("tx_hdr", tx_hdr, tx_udp_hdr_q.pop_front());
        end else begin
          if (tx_raw_hdr_q.size() == 0) unexpected("tx_hdr");
          else check_hdr("tx_hdr", tx_hdr, tx_raw_hdr_q.pop_front());
        end
      end
      if (tx_beat_valid && tx_beat_ready) begin
        if (beat_src != 0 && beat_src != ((tx_beat.data[63:56] == TAG_UDP) ? 1 : 2)) begin
          $display("frames interleaved on tx_beat");
          errors++;
        end
        beat_src = (tx_beat.data[63:56] == TAG_UDP) ? 1 : 2;
        if (beat_src == 1) begin
          if (tx_udp_beat_q.size() == 0) unexpected("tx_beat");
          else check_beat("tx_beat", tx_beat, tx_udp_beat_q.pop_front());
        end else begin
          if (tx_raw_beat_q.size() == 0) unexpected("tx_beat");
          else check_beat("tx_beat", tx_beat, tx_raw_beat_q.pop_front());
        end
        if (tx_beat.last) beat_src = 0;
      end
    end
  end

  always @(negedge clk) begin
    if (rand_ready) begin
      udp_rx_hdr_ready <= 2'(next_rand()) != 2'b00;
      udp_rx_beat_ready <= 2'(next_rand()) != 2'b00;
      ip_rx_hdr_ready <= 2'(next_rand()) != 2'b00;
      ip_rx_beat_ready <= 2'(next_rand()) != 2'b00;
      tx_hdr_ready <= 2'(next_rand()) != 2'b00;
      tx_beat_ready <= 2'(next_rand()) != 2'b00;
    end else begin
      udp_rx_hdr_ready <= 1'b1;
      udp_rx_beat_ready <= 1'b1;
      ip_rx_hdr_ready <= 1'b1;
      ip_rx_beat_ready <= 1'b1;
      tx_hdr_ready <= 1'b1;
      tx_beat_ready <= 1'b1;
    end
  end

  task automatic send_rx(input ip_hdr_t h, input int n);
    beat_t b[MAX_BEATS];
    for (int i = 0; i < n; i++) b[i] = make_beat(8'h3c, i == n - 1);
    if (h.protocol == 8'd17) begin
      udp_rx_hdr_q.push_back(h);
      for (int i = 0; i < n; i++) udp_rx_beat_q.push_back(b[i]);
    end else begin
      ip_rx_hdr_q.push_back(h);
      for (int i = 0; i < n; i++) ip_rx_beat_q.push_back(b[i]);
    end
    @(negedge clk);
    rx_hdr = h;
    rx_hdr_valid = 1'b1;
    do @(posedge clk); while (!rx_hdr_ready);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      rx_hdr_valid = 1'b0;
      rx_beat = b[i];
      rx_beat_valid = 1'b1;
      do @(posedge clk); while (!rx_beat_ready);
    end
    @(negedge clk);
    rx_beat_valid = 1'b0;
  endtask

  task automatic send_udp(input udp_hdr_t u, input int n);
    beat_t b[MAX_BEATS];
    for (int i = 0; i < n; i++) b[i] = make_beat(TAG_UDP, i == n - 1);
    tx_udp_hdr_q.push_back(expect_framed(u));
    for (int i = 0; i < n; i++) tx_udp_beat_q.push_back(b[i]);
    @(negedge clk);
    udp_tx_hdr = u;
    udp_tx_hdr_valid = 1'b1;
    do @(posedge clk); while (!udp_tx_hdr_ready);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      udp_tx_hdr_valid = 1'b0;
      udp_tx_beat = b[i];
      udp_tx_beat_valid = 1'b1;
      do @(posedge clk); while (!udp_tx_beat_ready);
    end
    @(negedge clk);
    udp_tx_beat_valid = 1'b0;
  endtask

  task automatic send_raw(input ip_hdr_t h, input int n);
    beat_t b[MAX_BEATS];
    for (int i = 0; i < n; i++) b[i] = make_beat(TAG_RAW, i == n - 1);
    tx_raw_hdr_q.push_back(h);
    for (int i = 0; i < n; i++) tx_raw_beat_q.push_back(b[i]);
    @(negedge clk);
    raw_tx_hdr = h;
    raw_tx_hdr_valid = 1'b1;
    do @(posedge clk); while (!raw_tx_hdr_ready);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      raw_tx_hdr_valid = 1'b0;
      raw_tx_beat = b[i];
      raw_tx_beat_valid = 1'b1;
      do @(posedge clk); while (!raw_tx_beat_ready);
    end
    @(negedge clk);
    raw_tx_beat_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (udp_rx_hdr_q.size() + udp_rx_beat_q.size() + ip_rx_hdr_q.size() +
           ip_rx_beat_q.size() + tx_udp_hdr_q.size() + tx_udp_beat_q.size() +
           tx_raw_hdr_q.size() + tx_raw_beat_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (total_errors() > errors_before) tests_failed++;
    $display("test %0d %s: %s", tests_run, name,
             (total_errors() > errors_before) ? "fail" : "pass");
  endtask

  // Watchdog sized from the test count and frame length
  initial begin
    #(NUM_TESTS * MAX_BEATS * 200 * PERIOD);
    $display("timeout: the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int e;
    rst = 1'b1;
    rand_ready = 1'b0;
    rx_hdr_valid = 1'b0;
    rx_beat_valid = 1'b0;
    udp_tx_hdr_valid = 1'b0;
    udp_tx_beat_valid = 1'b0;
    raw_tx_hdr_valid = 1'b0;
    raw_tx_beat_valid = 1'b0;
    rx_hdr = '0;
    rx_beat = '0;
    udp_tx_hdr = '0;
    udp_tx_beat = '0;
    raw_tx_hdr = '0;
    raw_tx_beat = '0;
    udp_rx_hdr_ready = 1'b1;
    udp_rx_beat_ready = 1'b1;
    ip_rx_hdr_ready = 1'b1;
    ip_rx_beat_ready = 1'b1;
    tx_hdr_ready = 1'b1;
    tx_beat_ready = 1'b1;
    beat_src = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e = total_errors();
    repeat (10) begin
      @(posedge clk);
      if (udp_rx_hdr_valid || udp_rx_beat_valid || ip_rx_hdr_valid || ip_rx_beat_valid ||
          tx_hdr_valid || tx_beat_valid) begin
        $display("output valid high with no input");
        errors++;
      end
    end
    finish_test("idle after reset", e);

    e = total_errors();
    for (int i = 0; i < 12; i++) send_rx(rand_ip_hdr(1'(next_rand())), rand_len());
    wait_drained();
    finish_test("receive classifier", e);

    e = total_errors();
    for (int i = 0; i < 10; i++) send_udp(rand_udp_hdr(1'(next_rand())), rand_len());
    wait_drained();
    finish_test("udp framer", e);

    e = total_errors();
    for (int i = 0; i < 10; i++) send_raw(rand_ip_hdr(1'b0), rand_len());
    wait_drained();
    finish_test("raw send", e);

    // Raw header starts a cycle late to meet the framed header at the arbiter
    e = total_errors();
    for (int i = 0; i < 6; i++) begin
      hdr_order.delete();
      fork
        send_udp(rand_udp_hdr(1'(next_rand())), rand_len());
        begin
          @(negedge clk);
          send_raw(rand_ip_hdr(1'b0), rand_len());
        end
      join
      wait_drained();
      if (hdr_order.size() == 0 || hdr_order[0] != 1'b1) begin
        $display("raw frame was granted ahead of a pending UDP frame");
        errors++;
      end
    end
    finish_test("arbiter priority", e);

    e = total_errors();
    rand_ready = 1'b1;
    fork
      for (int i = 0; i < 10; i++) send_rx(rand_ip_hdr(1'(next_rand())), rand_len());
      for (int i = 0; i < 10; i++) send_udp(rand_udp_hdr(1'(next_rand())), rand_len());
      for (int i = 0; i < 10; i++) send_raw(rand_ip_hdr(1'b0), rand_len());
    join
    wait_drained();
    rand_ready = 1'b0;
    finish_test("random back-pressure", e);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
common/udp_ip_pkg.sv
design/skid_buffer.sv
rx/ip_rx_demux.sv
tx/udp_tx_framer.sv
tx/ip_tx_arbiter.sv
design/udp_ip_switch.sv
test/udp_ip_switch_asserts.sv
test/tb_udp_ip_switch.sv

// File: Makefile
# Verilator build and run for the UDP/IP switch

VERILATOR ?= verilator
TOP       ?= tb_udp_ip_switch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
